//--- force_pkg.sv
// Force write-back types
// Shared widths and structs for the home-cell force path: force components,
// cell coordinates, particle addresses and the queued partial-force record

package force_pkg;

	////////////////////
	// Scalar widths
	////////////////////

	// IEEE single precision component
	typedef logic [31:0] force_value_t;
	// One coordinate of a cell
	typedef logic [3:0] cell_id_t;
	// Particle slot inside a cell
	typedef logic [8:0] cell_addr_t;
	// {cell_x, cell_y, cell_z, cell_addr}
	typedef logic [20:0] particle_id_t;

	// Cell fields start right above the address
	localparam int CELL_ID_LSB = $bits(cell_addr_t);

	////////////////////
	// Records
	////////////////////

	// Three force components, x on top
	typedef struct packed {
		force_value_t x;
		force_value_t y;
		force_value_t z;
	} force_vec_t;

	// Filtered force waiting for accumulation
	typedef struct packed {
		cell_addr_t addr;
		force_vec_t vec;
	} partial_force_t;

endpackage

//--- fp_adder.sv
// Single-precision adder, three pipeline stages
// Align, add/subtract, normalize. Result is truncated, no rounding.
// No NaN, infinity or denormal handling; a zero exponent means zero

`timescale 1ns/1ps

module fp_adder (
	input  logic                    clk,
	input  logic                    arst_n,
	input  force_pkg::force_value_t a,
	input  force_pkg::force_value_t b,
	output force_pkg::force_value_t sum
);

	// Leading zeros of a 24-bit mantissa
	function automatic logic [4:0] lead_zeros(input logic [23:0] m);
		logic [4:0] lz;
		logic       found;
		lz = '0;
		found = 1'b0;
		for (int i = 23; i >= 0; i--) begin
			if (!found) begin
				if (m[i])
					found = 1'b1;
				else
					lz = lz + 5'd1;
			end
		end
		return lz;
	endfunction

	////////////////////
	// Stage 1: align
	////////////////////
	logic        a_big;
	logic [30:0] big_mag, small_mag;
	logic [7:0]  exp_diff;
	logic [23:0] man_big, man_small;
	logic        s1_sign, s1_sub;
	logic [7:0]  s1_exp;
	logic [23:0] s1_man_big, s1_man_small;

	// Larger magnitude decides the result sign and exponent
	assign a_big = a[30:0] >= b[30:0];
	assign big_mag = a_big ? a[30:0] : b[30:0];
	assign small_mag = a_big ? b[30:0] : a[30:0];
	assign exp_diff = big_mag[30:23] - small_mag[30:23];
	// Hidden bit only for nonzero exponent, so a zero operand adds nothing
	assign man_big = {big_mag[30:23] != 8'd0, big_mag[22:0]};
	assign man_small = {small_mag[30:23] != 8'd0, small_mag[22:0]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_sign <= 1'b0;
			s1_sub <= 1'b0;
			s1_exp <= '0;
			s1_man_big <= '0;
			s1_man_small <= '0;
		end else begin
			s1_sign <= a_big ? a[31] : b[31];
			s1_sub <= a[31] ^ b[31];
			s1_exp <= big_mag[30:23];
			s1_man_big <= man_big;
			// Shifted-out bits are simply lost
			s1_man_small <= (exp_diff >= 8'd24) ? '0 : man_small >> exp_diff;
		end
	end

	////////////////////
	// Stage 2: add
	////////////////////
	logic        s2_sign;
	logic [7:0]  s2_exp;
	logic [24:0] s2_man;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s2_sign <= 1'b0;
			s2_exp <= '0;
			s2_man <= '0;
		end else begin
			s2_sign <= s1_sign;
			s2_exp <= s1_exp;
			// Big minus small never goes negative
			s2_man <= s1_sub ? {1'b0, s1_man_big} - {1'b0, s1_man_small}
			                 : {1'b0, s1_man_big} + {1'b0, s1_man_small};
		end
	end

	////////////////////
	// Stage 3: normalize
	////////////////////
	logic [4:0]  lz;
	logic [23:0] man_norm;
	logic [7:0]  exp_norm;

	always_comb begin
		lz = lead_zeros(s2_man[23:0]);
		if (s2_man[24]) begin
			// Carry out, drop one LSB
			man_norm = s2_man[24:1];
			exp_norm = s2_exp + 8'd1;
		end else begin
			man_norm = s2_man[23:0] << lz;
			exp_norm = s2_exp - {3'd0, lz};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sum <= '0;
		else if (s2_man == '0)
			sum <= '0;
		else
			sum <= {s2_sign, exp_norm, man_norm[22:0]};
	end

endmodule

//--- force_input_buffer.sv
// Input FIFO for home-cell partial forces
// Absorbs stalls from read-out and address hazards. A push into a full
// buffer without a pop in the same cycle is lost and sets a sticky flag

`timescale 1ns/1ps

module force_input_buffer #(
	parameter int FORCE_CACHE_BUFFER_DEPTH = 16
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      push,
	input  force_pkg::partial_force_t push_data,
	input  logic                      pop,
	output force_pkg::partial_force_t head,
	output logic                      empty,
	output logic                      overflow
);

	localparam int PTR_W = $clog2(FORCE_CACHE_BUFFER_DEPTH);
	localparam int CNT_W = $clog2(FORCE_CACHE_BUFFER_DEPTH + 1);

	force_pkg::partial_force_t mem [FORCE_CACHE_BUFFER_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic full, push_ok, pop_ok;

	assign empty = count == '0;
	assign full = count == CNT_W'(FORCE_CACHE_BUFFER_DEPTH);
	// A pop frees a slot in the same cycle
	assign push_ok = push && (!full || pop);
	assign pop_ok = pop && !empty;
	assign head = mem[rd_ptr];

	// Pointers wrap at DEPTH, any depth works
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == PTR_W'(FORCE_CACHE_BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_W'(FORCE_CACHE_BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (!push_ok && pop_ok)
				count <= count - 1'b1;
			// Sticky until reset
			if (push && !push_ok)
				overflow <= 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

endmodule

//--- force_cache_ram.sv
// Force cache memory
// One read port, one write port, one cycle read latency.
// Write-before-read on an address collision. Entries never written
// since reset read as zero through a per-address valid bit

`timescale 1ns/1ps

module force_cache_ram #(
	parameter int MAX_CELL_PARTICLE_NUM = 290
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  force_pkg::cell_addr_t rd_addr,
	output force_pkg::force_vec_t rd_data,
	input  logic                  wr_en,
	input  force_pkg::cell_addr_t wr_addr,
	input  force_pkg::force_vec_t wr_data
);

	force_pkg::force_vec_t mem [MAX_CELL_PARTICLE_NUM];
	logic [MAX_CELL_PARTICLE_NUM-1:0] entry_valid;
	logic wr_ok, rd_ok;

	// Addresses past the last particle are ignored
	assign wr_ok = wr_en && (wr_addr < MAX_CELL_PARTICLE_NUM);
	assign rd_ok = rd_addr < MAX_CELL_PARTICLE_NUM;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			entry_valid <= '0;
		else if (wr_ok)
			entry_valid[wr_addr] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_addr] <= wr_data;
		// Bypass: fresh write wins over stored value
		if (wr_ok && wr_addr == rd_addr)
			rd_data <= wr_data;
		else if (rd_ok && entry_valid[rd_addr])
			rd_data <= mem[rd_addr];
		else
			rd_data <= '0;
	end

endmodule

//--- force_accumulator.sv
// Force accumulator
// Pops queued forces, reads the running total from the cache, adds the
// partial force with three pipelined adders and writes the sum back.
// A four-stage tracker blocks a second item for an address still in flight

`timescale 1ns/1ps

module force_accumulator #(
	parameter int MAX_CELL_PARTICLE_NUM = 290
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      pause,
	input  force_pkg::partial_force_t head,
	input  logic                      empty,
	output logic                      pop,
	output force_pkg::cell_addr_t     cache_rd_addr,
	input  force_pkg::force_vec_t     cache_rd_data,
	output logic                      cache_wr_en,
	output force_pkg::cell_addr_t     cache_wr_addr,
	output force_pkg::force_vec_t     cache_wr_data
);

	// Read return plus three adder stages
	localparam int PIPE_DEPTH = 4;

	logic [PIPE_DEPTH-1:0] stage_valid;
	force_pkg::cell_addr_t stage_addr [PIPE_DEPTH];
	// Partial force only needed until the cache data comes back
	force_pkg::force_vec_t stage0_vec;
	logic hazard, issue, addr_ok;

	////////////////////
	// Issue and hazard
	////////////////////

	// RAW check against everything still in flight
	always_comb begin
		hazard = 1'b0;
		for (int i = 0; i < PIPE_DEPTH; i++) begin
			if (stage_valid[i] && stage_addr[i] == head.addr)
				hazard = 1'b1;
		end
	end

	assign issue = !empty && !pause && !hazard;
	assign pop = issue;
	// Out-of-range slot is popped and dropped
	assign addr_ok = head.addr < MAX_CELL_PARTICLE_NUM;
	// Read address goes out in the issue cycle
	assign cache_rd_addr = head.addr;

	////////////////////
	// In-flight tracker
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			stage_valid <= '0;
		else
			stage_valid <= {stage_valid[PIPE_DEPTH-2:0], issue && addr_ok};
	end

	always_ff @(posedge clk) begin
		stage_addr[0] <= head.addr;
		for (int i = 1; i < PIPE_DEPTH; i++)
			stage_addr[i] <= stage_addr[i-1];
		stage0_vec <= head.vec;
	end

	////////////////////
	// Adders
	////////////////////

	// Cache total + partial, lined up at stage 0
	fp_adder fp_adder_x (
		.clk    (clk),
		.arst_n (arst_n),
		.a      (cache_rd_data.x),
		.b      (stage0_vec.x),
		.sum    (cache_wr_data.x)
	);

	fp_adder fp_adder_y (
		.clk    (clk),
		.arst_n (arst_n),
		.a      (cache_rd_data.y),
		.b      (stage0_vec.y),
		.sum    (cache_wr_data.y)
	);

	fp_adder fp_adder_z (
		.clk    (clk),
		.arst_n (arst_n),
		.a      (cache_rd_data.z),
		.b      (stage0_vec.z),
		.sum    (cache_wr_data.z)
	);

	// Sum is ready when the item reaches the last stage
	assign cache_wr_en = stage_valid[PIPE_DEPTH-1];
	assign cache_wr_addr = stage_addr[PIPE_DEPTH-1];

endmodule

//--- force_write_back_controller.sv
// Top level of the force write-back controller
// Filters incoming partial forces to the home cell, queues them, and
// accumulates them into the force cache. A read request pauses issue
// and hands the cache read port to the external address

`timescale 1ns/1ps

module force_write_back_controller #(
	parameter force_pkg::cell_id_t CELL_X = 4'd2,
	parameter force_pkg::cell_id_t CELL_Y = 4'd2,
	parameter force_pkg::cell_id_t CELL_Z = 4'd2,
	parameter int FORCE_CACHE_BUFFER_DEPTH = 16,
	parameter int MAX_CELL_PARTICLE_NUM = 290
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    in_partial_force_valid,
	input  force_pkg::particle_id_t in_particle_id,
	input  force_pkg::force_vec_t   in_partial_force,
	input  logic                    in_read_data_request,
	input  force_pkg::cell_addr_t   in_cache_read_address,
	output force_pkg::force_vec_t   out_partial_force,
	output logic                    out_cache_readout_valid,
	output logic                    out_buffer_overflow
);

	localparam int CELL_W = $bits(force_pkg::cell_id_t);

	force_pkg::partial_force_t push_data, head;
	force_pkg::cell_addr_t acc_rd_addr, cache_rd_addr, cache_wr_addr;
	force_pkg::force_vec_t cache_wr_data;
	logic home_cell, push, pop, empty, cache_wr_en;

	////////////////////
	// Home-cell filter
	////////////////////

	// ID layout {x, y, z, addr}
	assign home_cell =
		in_particle_id[force_pkg::CELL_ID_LSB +: 3*CELL_W] == {CELL_X, CELL_Y, CELL_Z};
	assign push = in_partial_force_valid && home_cell;
	assign push_data = '{addr: in_particle_id[force_pkg::CELL_ID_LSB-1:0], vec: in_partial_force};

	force_input_buffer #(
		.FORCE_CACHE_BUFFER_DEPTH (FORCE_CACHE_BUFFER_DEPTH)
	) force_input_buffer_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.head      (head),
		.empty     (empty),
		.overflow  (out_buffer_overflow)
	);

	force_accumulator #(
		.MAX_CELL_PARTICLE_NUM (MAX_CELL_PARTICLE_NUM)
	) force_accumulator_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.pause         (in_read_data_request),
		.head          (head),
		.empty         (empty),
		.pop           (pop),
		.cache_rd_addr (acc_rd_addr),
		.cache_rd_data (out_partial_force),
		.cache_wr_en   (cache_wr_en),
		.cache_wr_addr (cache_wr_addr),
		.cache_wr_data (cache_wr_data)
	);

	////////////////////
	// Readout path
	////////////////////

	// External address owns the read port during a request
	assign cache_rd_addr = in_read_data_request ? in_cache_read_address : acc_rd_addr;

	force_cache_ram #(
		.MAX_CELL_PARTICLE_NUM (MAX_CELL_PARTICLE_NUM)
	) force_cache_ram_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.rd_addr (cache_rd_addr),
		.rd_data (out_partial_force),
		.wr_en   (cache_wr_en),
		.wr_addr (cache_wr_addr),
		.wr_data (cache_wr_data)
	);

	// Matches the one-cycle read latency
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_cache_readout_valid <= 1'b0;
		else
			out_cache_readout_valid <= in_read_data_request;
	end

endmodule

//--- force_write_back_controller_sva.sv
// Bound checks on the write-back controller top
// Readout valid timing and the sticky buffer overflow flag

`timescale 1ns/1ps

module force_write_back_controller_sva (
	input logic clk,
	input logic arst_n,
	input logic in_read_data_request,
	input logic out_cache_readout_valid,
	input logic out_buffer_overflow
);

	// Outputs quiet while reset is held
	assert property (@(posedge clk) !arst_n |-> !out_cache_readout_valid && !out_buffer_overflow)
	else $error("Readout valid or overflow high during reset");

	// Valid is the request one cycle late
	assert property (@(posedge clk) disable iff (!arst_n)
		out_cache_readout_valid == $past(in_read_data_request))
	else $error("Readout valid does not follow the read request by one cycle");

	// Overflow never clears on its own
	assert property (@(posedge clk) disable iff (!arst_n)
		out_buffer_overflow |=> out_buffer_overflow)
	else $error("Buffer overflow flag fell without a reset");

endmodule

bind force_write_back_controller force_write_back_controller_sva force_write_back_controller_sva_i (
	.clk                     (clk),
	.arst_n                  (arst_n),
	.in_read_data_request    (in_read_data_request),
	.out_cache_readout_valid (out_cache_readout_valid),
	.out_buffer_overflow     (out_buffer_overflow)
);

//--- force_write_back_controller_tb.sv
// Testbench for the force write-back controller
// Random home-cell bursts with foreign-cell forces mixed in, readouts
// compared against an integer sum model, pause and overflow scenarios

`timescale 1ns/1ps

module force_write_back_controller_tb;

	localparam force_pkg::cell_id_t HOME_X = 4'd2;
	localparam force_pkg::cell_id_t HOME_Y = 4'd2;
	localparam force_pkg::cell_id_t HOME_Z = 4'd2;
	localparam int DEPTH = 16;
	localparam int NUM_ADDR = 9;
	// About three times the length of all tests
	localparam int MAX_CYCLES = 3000;

	logic clk = 1'b0;
	logic arst_n;
	logic in_partial_force_valid;
	force_pkg::particle_id_t in_particle_id;
	force_pkg::force_vec_t in_partial_force;
	logic in_read_data_request;
	force_pkg::cell_addr_t in_cache_read_address;
	force_pkg::force_vec_t out_partial_force;
	logic out_cache_readout_valid;
	logic out_buffer_overflow;

	int seed = 70450;
	int cycle_count = 0;
	// Reference sums per address in whole units
	int sum_x [NUM_ADDR];
	int sum_y [NUM_ADDR];
	int sum_z [NUM_ADDR];

	force_write_back_controller #(
		.CELL_X                   (HOME_X),
		.CELL_Y                   (HOME_Y),
		.CELL_Z                   (HOME_Z),
		.FORCE_CACHE_BUFFER_DEPTH (DEPTH),
		.MAX_CELL_PARTICLE_NUM    (290)
	) force_write_back_controller_i (
		.clk                     (clk),
		.arst_n                  (arst_n),
		.in_partial_force_valid  (in_partial_force_valid),
		.in_particle_id          (in_particle_id),
		.in_partial_force        (in_partial_force),
		.in_read_data_request    (in_read_data_request),
		.in_cache_read_address   (in_cache_read_address),
		.out_partial_force       (out_partial_force),
		.out_cache_readout_valid (out_cache_readout_valid),
		.out_buffer_overflow     (out_buffer_overflow)
	);

	always #10 clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at first error");
	endtask

	// Exact for 0 <= v < 2^24
	function automatic force_pkg::force_value_t to_float(input int v);
		int msb;
		logic [31:0] u;
		logic [31:0] shifted;
		msb = 0;
		u = v;
		if (v == 0)
			return '0;
		for (int i = 0; i < 24; i++) begin
			if (u[i])
				msb = i;
		end
		// Hidden bit lands on bit 23 and is dropped
		shifted = u << (23 - msb);
		return {1'b0, 8'(127 + msb), shifted[22:0]};
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		return lo + int'($unsigned(r) % (hi - lo + 1));
	endfunction

	// One valid cycle that ends on the edge dropping valid
	task automatic send_force(input force_pkg::cell_id_t cx, input force_pkg::cell_id_t cy,
		input force_pkg::cell_id_t cz, input int addr, input int fx, input int fy, input int fz);
		@(posedge clk);
		in_partial_force_valid <= 1'b1;
		in_particle_id <= {cx, cy, cz, force_pkg::cell_addr_t'(addr)};
		in_partial_force <= '{x: to_float(fx), y: to_float(fy), z: to_float(fz)};
		@(posedge clk);
		in_partial_force_valid <= 1'b0;
	endtask

	// Home-cell force that is optionally booked into the model
	task automatic send_home(input int addr, input bit counted);
		int fx;
		int fy;
		int fz;
		fx = rand_range(1, 4);
		fy = rand_range(1, 4);
		fz = rand_range(1, 4);
		send_force(HOME_X, HOME_Y, HOME_Z, addr, fx, fy, fz);
		if (counted) begin
			sum_x[addr] += fx;
			sum_y[addr] += fy;
			sum_z[addr] += fz;
		end
	endtask

	// Model update in the same draw order as send_home
	task automatic book_replay(input int addr);
		sum_x[addr] += rand_range(1, 4);
		sum_y[addr] += rand_range(1, 4);
		sum_z[addr] += rand_range(1, 4);
	endtask

	// Any cell but home that must never reach the cache
	task automatic send_foreign();
		force_pkg::cell_id_t cx;
		force_pkg::cell_id_t cy;
		force_pkg::cell_id_t cz;
		cx = force_pkg::cell_id_t'(rand_range(0, 15));
		cy = force_pkg::cell_id_t'(rand_range(0, 15));
		cz = force_pkg::cell_id_t'(rand_range(0, 15));
		if (cx == HOME_X && cy == HOME_Y && cz == HOME_Z)
			cz = HOME_Z + 4'd1;
		send_force(cx, cy, cz, rand_range(1, 8), rand_range(1, 4), rand_range(1, 4),
			rand_range(1, 4));
	endtask

	// Buffer empty and nothing in flight
	task automatic wait_drained();
		do
			@(negedge clk);
		while (!(force_write_back_controller_i.empty &&
			force_write_back_controller_i.force_accumulator_i.stage_valid == '0));
	endtask

	// Pipelined readout of addresses 0..8 at one per cycle
	task automatic read_and_check(input string test_name);
		force_pkg::force_vec_t expected;
		@(posedge clk);
		in_read_data_request <= 1'b1;
		in_cache_read_address <= '0;
		for (int a = 1; a <= NUM_ADDR; a++) begin
			@(posedge clk);
			if (a < NUM_ADDR)
				in_cache_read_address <= force_pkg::cell_addr_t'(a);
			else
				in_read_data_request <= 1'b0;
			@(negedge clk);
			expected = '{x: to_float(sum_x[a-1]), y: to_float(sum_y[a-1]),
				z: to_float(sum_z[a-1])};
			assert (out_cache_readout_valid)
			else fail_now($sformatf("Readout valid missing in %s at address %0d",
				test_name, a - 1));
			assert (out_partial_force == expected)
			else fail_now($sformatf("[FAIL] %s addr %0d expected %h actual %h",
				test_name, a - 1, expected, out_partial_force));
		end
	endtask

	////////////////////
	// Timeout
	////////////////////

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			fail_now($sformatf("Timeout, the tests did not finish within %0d cycles",
				MAX_CYCLES));
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int addr;
		int prev_addr;
		int pause_seed;
		arst_n = 1'b0;
		in_partial_force_valid = 1'b0;
		in_particle_id = '0;
		in_partial_force = '0;
		in_read_data_request = 1'b0;
		in_cache_read_address = '0;
		for (int i = 0; i < NUM_ADDR; i++) begin
			sum_x[i] = 0;
			sum_y[i] = 0;
			sum_z[i] = 0;
		end
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		// Accumulation burst with foreign cells mixed in
		prev_addr = 1;
		for (int n = 0; n < 200; n++) begin
			// Every tenth force repeats the previous address
			addr = (n % 10 == 9) ? prev_addr : rand_range(1, 8);
			send_home(addr, 1'b1);
			prev_addr = addr;
			if (n % 4 == 3)
				send_foreign();
			@(posedge clk);
		end
		wait_drained();
		assert (!out_buffer_overflow)
		else fail_now("Buffer overflow flag set during the paced burst");
		read_and_check("accumulate");

		// Forces held back while the request is high
		pause_seed = seed;
		@(posedge clk);
		in_read_data_request <= 1'b1;
		for (int n = 0; n < 6; n++)
			send_home(rand_range(1, 8), 1'b0);
		// Totals unchanged while the forces wait in the buffer
		read_and_check("pause_hold");
		// Same draws again, now booked into the model
		seed = pause_seed;
		for (int n = 0; n < 6; n++)
			book_replay(rand_range(1, 8));
		wait_drained();
		read_and_check("pause_release");
		assert (!out_buffer_overflow)
		else fail_now("Buffer overflow flag set before the overflow test");

		// Overflow with issue paused
		@(posedge clk);
		in_read_data_request <= 1'b1;
		for (int n = 0; n < 20; n++)
			send_home(rand_range(1, 8), n < DEPTH);
		@(negedge clk);
		assert (out_buffer_overflow)
		else fail_now("Buffer overflow flag did not rise after 20 paused forces");
		@(posedge clk);
		in_read_data_request <= 1'b0;
		wait_drained();
		read_and_check("overflow");
		assert (out_buffer_overflow)
		else fail_now("Buffer overflow flag cleared without a reset");

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- build.f
force_pkg.sv
fp_adder.sv
force_input_buffer.sv
force_cache_ram.sv
force_accumulator.sv
force_write_back_controller.sv
force_write_back_controller_sva.sv
force_write_back_controller_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module force_write_back_controller_tb -o force_write_back_controller_sim

./obj_dir/force_write_back_controller_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
grep -q "Finished with no errors" sim.log
